// ==== src/cpuCtl_cfg.svh ====
// cpuCtl config: bus vectors, reset values, decoded opcodes and step width
`ifndef CPU_CTL_CFG_SVH
`define CPU_CTL_CFG_SVH

// T-step counter width, longest sequence is 8 steps
`define CPU_STEP_BITS 3

// restart addresses
`define CPU_NMI_VECTOR 16'h0066
`define CPU_INT_VECTOR 16'h0038

// register values after the reset step
`define CPU_PC_RESET 16'h0000
`define CPU_SP_RESET 16'hFFFF

// opcodes recognised during fetch
`define CPU_OP_EI 8'hFB
`define CPU_OP_DI 8'hF3

`endif

// ==== src/cpuCtlPkg.sv ====
// cpuCtlPkg: shared vector types and the machine sequence encoding
`default_nettype none

`include "cpuCtl_cfg.svh"

package cpuCtlPkg;

    typedef logic [15:0] addrT;                 // bus address, PC, SP, I:R
    typedef logic [7:0] byteT;                  // data byte or opcode
    typedef logic [`CPU_STEP_BITS-1:0] stepT;   // T-step within a sequence

    // active machine sequence
    typedef enum logic [2:0] {
        seqReset,
        seqBusGrant,
        seqFetch,
        seqNmi,
        seqInt
    } seqT;

endpackage

`default_nettype wire

// ==== src/stepCounter.sv ====
// stepCounter: T-step counter with wait stretching and sequence restart
`default_nettype none
`timescale 1ns/1ps

module stepCounter
    import cpuCtlPkg::*;
(
    input  logic Clk,
    input  logic rstN,
    input  logic seqRestart,
    input  logic waitable,
    input  logic waitReq,
    output stepT step,
    output logic stepAdvance
);

    // a waitable step repeats while the bus holds waitReq
    assign stepAdvance = !(waitable && waitReq);

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            step <= '0;
        end else if (stepAdvance) begin
            step <= seqRestart ? '0 : step + stepT'(1);
        end
    end

    // the decoder must end every sequence by step 7, no wrap to 0 by overflow
    stepNoWrap: assert property (
        @(posedge Clk) disable iff (!rstN)
        (stepAdvance && step == '1) |-> seqRestart
    ) else $error("step counter would pass its last step");

endmodule

`default_nettype wire

// ==== src/cycleDecoder.sv ====
// cycleDecoder: priority sequence selection and per-step strobe decode
`default_nettype none
`timescale 1ns/1ps

`include "cpuCtl_cfg.svh"

module cycleDecoder
    import cpuCtlPkg::*;
(
    input  logic Clk,
    input  logic rstN,
    input  logic busRq,
    input  logic nmi,
    input  logic intReq,
    input  logic waitReq,
    input  stepT step,
    input  logic stepAdvance,
    input  byteT opcode,
    output logic seqRestart,
    output logic waitable,
    output logic clearRegs,
    output logic loadVector,
    output logic vectorSel,
    output logic incPc,
    output logic decSp,
    output logic incR,
    output logic latchOp,
    output logic selAdPc,
    output logic selAdIr,
    output logic selAdSp,
    output logic selDtPcHigh,
    output logic m1,
    output logic mreq,
    output logic rd,
    output logic wr,
    output logic iorq,
    output logic rfsh,
    output logic busAck
);

    seqT seq;
    seqT nextSeq;
    logic nmiQ;
    logic nmiPend;
    logic iff1;
    logic iff2;
    logic endSeq;
    logic opEi;
    logic opDi;
    logic iff1Eff;
    logic clearRaw;
    logic vecRaw;
    logic incPcRaw;
    logic decSpRaw;
    logic incRRaw;
    logic latchRaw;

    assign endSeq = stepAdvance && seqRestart;
    assign opEi = endSeq && seq == seqFetch && opcode == byteT'(`CPU_OP_EI);
    assign opDi = endSeq && seq == seqFetch && opcode == byteT'(`CPU_OP_DI);
    // EI/DI and the NMI iff1 clear count already at the boundary they end on
    assign iff1Eff = opEi || (iff1 && !opDi && seq != seqNmi);

    always_comb begin
        if (busRq) nextSeq = seqBusGrant;
        else if (nmiPend) nextSeq = seqNmi;
        else if (intReq && iff1Eff) nextSeq = seqInt;
        else nextSeq = seqFetch;
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            seq <= seqReset;
            nmiQ <= 1'b0;
            nmiPend <= 1'b0;
            iff1 <= 1'b0;
            iff2 <= 1'b0;
        end else begin
            nmiQ <= nmi;
            if (endSeq) seq <= nextSeq;
            if (nmi && !nmiQ) nmiPend <= 1'b1;              // rising edge only
            else if (endSeq && nextSeq == seqNmi) nmiPend <= 1'b0;
            if (clearRegs || (endSeq && nextSeq == seqInt)) begin
                iff1 <= 1'b0;
                iff2 <= 1'b0;
            end else if (endSeq) begin
                iff1 <= iff1Eff;
                iff2 <= opEi || (iff2 && !opDi);
            end
        end
    end

    always_comb begin
        seqRestart = 1'b0;
        waitable = 1'b0;
        {clearRaw, vecRaw, incPcRaw, decSpRaw, incRRaw, latchRaw} = '0;
        {selAdPc, selAdIr, selAdSp, selDtPcHigh} = '0;
        {m1, mreq, rd, wr, iorq, rfsh, busAck} = '0;
        case (seq)
            seqReset: begin
                clearRaw = 1'b1;
                seqRestart = 1'b1;
            end
            seqBusGrant: begin
                busAck = 1'b1;
                seqRestart = 1'b1;                          // re-pick every cycle
            end
            default: begin
                if (step < stepT'(2)) begin                 // M1 part
                    selAdPc = 1'b1;
                    m1 = 1'b1;
                    waitable = step == stepT'(1);
                    if (seq == seqInt && step == stepT'(1)) begin
                        iorq = 1'b1;                        // int acknowledge
                    end else begin
                        mreq = 1'b1;
                        rd = 1'b1;
                    end
                    if (seq == seqFetch && step == stepT'(1)) begin
                        latchRaw = 1'b1;
                        incPcRaw = 1'b1;
                    end
                end else if (step < stepT'(4)) begin        // refresh part
                    selAdIr = 1'b1;
                    rfsh = 1'b1;
                    mreq = 1'b1;
                    if (step == stepT'(3)) begin
                        incRRaw = 1'b1;
                        if (seq == seqFetch) seqRestart = 1'b1;
                        else decSpRaw = 1'b1;
                    end
                end else begin
                    // push, high byte in 4/5 then low byte in 6/7
                    selAdSp = 1'b1;
                    mreq = 1'b1;
                    selDtPcHigh = step < stepT'(6);
                    if (step[0]) begin
                        wr = 1'b1;
                        waitable = 1'b1;
                        if (step == stepT'(7)) begin
                            vecRaw = 1'b1;
                            seqRestart = 1'b1;
                        end else begin
                            decSpRaw = 1'b1;
                        end
                    end
                end
            end
        endcase
    end

    // register side only moves on the cycle that closes a step
    assign clearRegs = clearRaw && stepAdvance;
    assign loadVector = vecRaw && stepAdvance;
    assign incPc = incPcRaw && stepAdvance;
    assign decSp = decSpRaw && stepAdvance;
    assign incR = incRRaw && stepAdvance;
    assign latchOp = latchRaw && stepAdvance;
    assign vectorSel = seq == seqNmi;

    addrSelOneHot: assert property (
        @(posedge Clk) disable iff (!rstN)
        $onehot0({selAdPc, selAdIr, selAdSp})
    ) else $error("more than one address select active");

    rdWrExclusive: assert property (
        @(posedge Clk) disable iff (!rstN)
        !(rd && wr)
    ) else $error("rd and wr active together");

endmodule

`default_nettype wire

// ==== src/regFile.sv ====
// regFile: PC, SP, I and R registers driven by the control strobes
`default_nettype none
`timescale 1ns/1ps

`include "cpuCtl_cfg.svh"

module regFile
    import cpuCtlPkg::*;
(
    input  logic Clk,
    input  logic rstN,
    input  logic clearRegs,
    input  logic loadVector,
    input  logic vectorSel,
    input  logic incPc,
    input  logic decSp,
    input  logic incR,
    output addrT pc,
    output addrT sp,
    output addrT ir
);

    byteT iReg;
    byteT rReg;

    assign ir = {iReg, rReg};

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `CPU_PC_RESET;
            sp <= `CPU_SP_RESET;
            iReg <= '0;
            rReg <= '0;
        end else if (clearRegs) begin
            pc <= `CPU_PC_RESET;
            sp <= `CPU_SP_RESET;
            iReg <= '0;
            rReg <= '0;
        end else begin
            if (loadVector) pc <= vectorSel ? `CPU_NMI_VECTOR : `CPU_INT_VECTOR;
            else if (incPc) pc <= pc + addrT'(1);
            if (decSp) sp <= sp - addrT'(1);
            // bit 7 of R is kept, only the low 7 bits count
            if (incR) rReg <= {rReg[7], rReg[6:0] + 7'd1};
        end
    end

    // decoder never jumps and advances PC in the same step
    pcStrobeExclusive: assert property (
        @(posedge Clk) disable iff (!rstN)
        !(incPc && loadVector)
    ) else $error("incPc and loadVector together");

endmodule

`default_nettype wire

// ==== src/busInterface.sv ====
// busInterface: address and data muxes, opcode latch, active-low bus strobes
`default_nettype none
`timescale 1ns/1ps

module busInterface
    import cpuCtlPkg::*;
(
    input  logic Clk,
    input  logic rstN,
    input  logic latchOp,
    input  byteT dataIn,
    input  addrT pc,
    input  addrT sp,
    input  addrT ir,
    input  logic selAdPc,
    input  logic selAdIr,
    input  logic selAdSp,
    input  logic selDtPcHigh,
    input  logic m1,
    input  logic mreq,
    input  logic rd,
    input  logic wr,
    input  logic iorq,
    input  logic rfsh,
    input  logic busAck,
    output addrT addr,
    output byteT dataOut,
    output byteT opcode,
    output logic m1N,
    output logic mreqN,
    output logic iorqN,
    output logic rdN,
    output logic wrN,
    output logic rfshN,
    output logic busAckN
);

    always_comb begin
        if (selAdPc) addr = pc;
        else if (selAdIr) addr = ir;       // refresh address
        else if (selAdSp) addr = sp;
        else addr = '0;                    // idle, reset or bus grant
    end

    assign dataOut = selDtPcHigh ? pc[15:8] : pc[7:0];

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) opcode <= '0;           // NOP
        else if (latchOp) opcode <= dataIn;
    end

    assign m1N = !m1;
    assign mreqN = !mreq;
    assign iorqN = !iorq;
    assign rdN = !rd;
    assign wrN = !wr;
    assign rfshN = !rfsh;
    assign busAckN = !busAck;

endmodule

`default_nettype wire

// ==== src/cpuCtlTop.sv ====
// cpuCtlTop: machine-cycle control, cycle decoder wired to the datapath blocks
`default_nettype none
`timescale 1ns/1ps

module cpuCtlTop
    import cpuCtlPkg::*;
(
    input  logic Clk,
    input  logic rstN,
    input  logic busRq,
    input  logic nmi,
    input  logic intReq,
    input  logic waitReq,
    input  byteT dataIn,
    output addrT addr,
    output byteT dataOut,
    output logic m1N,
    output logic mreqN,
    output logic iorqN,
    output logic rdN,
    output logic wrN,
    output logic rfshN,
    output logic busAckN
);

    stepT step;
    logic stepAdvance;
    logic seqRestart;
    logic waitable;
    logic clearRegs, loadVector, vectorSel, incPc, decSp, incR;
    logic latchOp, selAdPc, selAdIr, selAdSp, selDtPcHigh;
    logic m1, mreq, rd, wr, iorq, rfsh, busAck;
    addrT pc;
    addrT sp;
    addrT ir;
    byteT opcode;

    cycleDecoder decoder0 (
        .Clk(Clk),
        .rstN(rstN),
        .busRq(busRq),
        .nmi(nmi),
        .intReq(intReq),
        .waitReq(waitReq),
        .step(step),
        .stepAdvance(stepAdvance),
        .opcode(opcode),
        .seqRestart(seqRestart),
        .waitable(waitable),
        .clearRegs(clearRegs),
        .loadVector(loadVector),
        .vectorSel(vectorSel),
        .incPc(incPc),
        .decSp(decSp),
        .incR(incR),
        .latchOp(latchOp),
        .selAdPc(selAdPc),
        .selAdIr(selAdIr),
        .selAdSp(selAdSp),
        .selDtPcHigh(selDtPcHigh),
        .m1(m1),
        .mreq(mreq),
        .rd(rd),
        .wr(wr),
        .iorq(iorq),
        .rfsh(rfsh),
        .busAck(busAck)
    );

    stepCounter counter0 (
        .Clk(Clk),
        .rstN(rstN),
        .seqRestart(seqRestart),
        .waitable(waitable),
        .waitReq(waitReq),
        .step(step),
        .stepAdvance(stepAdvance)
    );

    regFile regs0 (
        .Clk(Clk),
        .rstN(rstN),
        .clearRegs(clearRegs),
        .loadVector(loadVector),
        .vectorSel(vectorSel),
        .incPc(incPc),
        .decSp(decSp),
        .incR(incR),
        .pc(pc),
        .sp(sp),
        .ir(ir)
    );

    busInterface bus0 (
        .Clk(Clk),
        .rstN(rstN),
        .latchOp(latchOp),
        .dataIn(dataIn),
        .pc(pc),
        .sp(sp),
        .ir(ir),
        .selAdPc(selAdPc),
        .selAdIr(selAdIr),
        .selAdSp(selAdSp),
        .selDtPcHigh(selDtPcHigh),
        .m1(m1),
        .mreq(mreq),
        .rd(rd),
        .wr(wr),
        .iorq(iorq),
        .rfsh(rfsh),
        .busAck(busAck),
        .addr(addr),
        .dataOut(dataOut),
        .opcode(opcode),
        .m1N(m1N),
        .mreqN(mreqN),
        .iorqN(iorqN),
        .rdN(rdN),
        .wrN(wrN),
        .rfshN(rfshN),
        .busAckN(busAckN)
    );

endmodule

`default_nettype wire

// ==== dv/cpuCtlTb.sv ====
// cpuCtlTb: table-driven testbench for fetch, wait, NMI, INT and bus grant sequences
`default_nettype none
`timescale 1ns/1ps

`include "cpuCtl_cfg.svh"

module cpuCtlTb
    import cpuCtlPkg::*;
();

    localparam logic [1:0] kindFetch = 2'd0;
    localparam logic [1:0] kindNmi = 2'd1;
    localparam logic [1:0] kindInt = 2'd2;

    // strobe vectors, order m1N mreqN iorqN rdN wrN rfshN busAckN
    localparam logic [6:0] strIdle = 7'b1111111;
    localparam logic [6:0] strM1Rd = 7'b0010111;
    localparam logic [6:0] strAck = 7'b0101111;
    localparam logic [6:0] strRfsh = 7'b1011101;
    localparam logic [6:0] strPush = 7'b1011111;
    localparam logic [6:0] strPushWr = 7'b1011011;
    localparam logic [6:0] strGrant = 7'b1111110;

    // one row is one fetch plus the sequence expected right after it
    typedef struct packed {
        logic busRq;
        logic nmi;
        logic intReq;
        byteT op;
        logic [1:0] kind;
    } rowT;

    localparam int numRows = 14;
    localparam rowT rowTab [numRows] = '{
        '{1'b0, 1'b0, 1'b0, 8'h00, kindFetch},
        '{1'b0, 1'b1, 1'b0, 8'h00, kindNmi},
        '{1'b0, 1'b0, 1'b1, 8'h00, kindFetch},        // IFFs still clear
        '{1'b0, 1'b0, 1'b1, `CPU_OP_EI, kindInt},
        '{1'b0, 1'b0, 1'b1, 8'h00, kindFetch},        // taken int cleared IFF1
        '{1'b0, 1'b0, 1'b0, `CPU_OP_EI, kindFetch},
        '{1'b0, 1'b0, 1'b1, `CPU_OP_DI, kindFetch},
        '{1'b0, 1'b0, 1'b1, 8'h00, kindFetch},
        '{1'b1, 1'b0, 1'b0, 8'h00, kindFetch},
        '{1'b1, 1'b1, 1'b0, 8'h00, kindNmi},          // grant first, NMI after
        '{1'b0, 1'b0, 1'b0, `CPU_OP_EI, kindFetch},
        '{1'b0, 1'b1, 1'b1, 8'h00, kindNmi},          // NMI beats INT
        '{1'b0, 1'b0, 1'b1, 8'h00, kindFetch},
        '{1'b0, 1'b0, 1'b0, 8'h00, kindFetch}
    };

    logic Clk;
    logic rstN;
    logic busRq;
    logic nmi;
    logic intReq;
    logic waitReq;
    byteT dataIn;
    addrT addr;
    byteT dataOut;
    logic m1N, mreqN, iorqN, rdN, wrN, rfshN, busAckN;

    rowT row;
    int cycleNo;
    int raiseAt;
    logic reqBus, reqNmi, reqInt, reqWait;
    addrT mPc;              // reference PC, SP and R
    addrT mSp;
    byteT mR;

    cpuCtlTop dut0 (
        .Clk(Clk), .rstN(rstN), .busRq(busRq), .nmi(nmi), .intReq(intReq),
        .waitReq(waitReq), .dataIn(dataIn), .addr(addr), .dataOut(dataOut),
        .m1N(m1N), .mreqN(mreqN), .iorqN(iorqN), .rdN(rdN), .wrN(wrN),
        .rfshN(rfshN), .busAckN(busAckN)
    );

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    // next cycle, inputs change 2 ns after the edge, return at the falling edge
    task automatic advanceCycle();
        @(posedge Clk);
        #2;
        if (cycleNo == raiseAt) begin
            reqBus = row.busRq;
            reqNmi = row.nmi;
            reqInt = row.intReq;
        end
        cycleNo++;
        busRq = reqBus;
        nmi = reqNmi;
        intReq = reqInt;
        waitReq = reqWait;
        dataIn = (!m1N && !rdN) ? row.op : 8'h00;     // memory answers reads only
        @(negedge Clk);
    endtask

    task automatic checkBus(input logic useAddr, input addrT expAddr, input logic [6:0] expStb);
        logic [6:0] gotStb;
        gotStb = {m1N, mreqN, iorqN, rdN, wrN, rfshN, busAckN};
        assert (gotStb === expStb) else
            abortRun($sformatf("ERR %0t strobes m1N..busAckN exp %b got %b",
                $time, expStb, gotStb));
        assert (!useAddr || addr === expAddr) else
            abortRun($sformatf("ERR %0t addr exp %h got %h", $time, expAddr, addr));
    endtask

    task automatic compareData(input byteT expByte);
        assert (dataOut === expByte) else
            abortRun($sformatf("ERR %0t dataOut exp %h got %h", $time, expByte, dataOut));
    endtask

    task automatic runSequence(input logic [1:0] kind);
        int w;
        byteT pushByte;
        w = int'($urandom_range(3));
        reqWait = 1'b0;
        advanceCycle();
        checkBus(1'b1, mPc, strM1Rd);
        for (int k = 0; k <= w; k++) begin
            reqWait = k < w;                           // stretch step 1
            advanceCycle();
            checkBus(1'b1, mPc, (kind == kindInt) ? strAck : strM1Rd);
        end
        reqWait = 1'b0;
        if (kind == kindFetch) mPc = mPc + 16'd1;
        repeat (2) begin
            advanceCycle();
            checkBus(1'b1, {8'h00, mR}, strRfsh);
        end
        mR[6:0] = mR[6:0] + 7'd1;
        if (kind != kindFetch) begin
            for (int b = 0; b < 2; b++) begin
                mSp = mSp - 16'd1;
                pushByte = (b == 0) ? mPc[15:8] : mPc[7:0];
                advanceCycle();
                checkBus(1'b1, mSp, strPush);
                advanceCycle();
                checkBus(1'b1, mSp, strPushWr);
                compareData(pushByte);
            end
            mPc = (kind == kindNmi) ? `CPU_NMI_VECTOR : `CPU_INT_VECTOR;
        end
    endtask

    task automatic runBusGrant();
        int n;
        int g;
        n = 0;
        g = 1 + int'($urandom_range(2));
        do begin
            if (n == 1) abortRun("timeout: bus request was not acknowledged after the fetch");
            advanceCycle();
            n++;
        end while (busAckN !== 1'b0);
        checkBus(1'b0, '0, strGrant);
        for (int k = 1; k <= g; k++) begin
            if (k == g) reqBus = 1'b0;                 // grant ends after this cycle
            advanceCycle();
            checkBus(1'b0, '0, strGrant);
        end
    endtask

    initial begin
        void'($urandom(39));
        rstN = 1'b0;
        busRq = 1'b0;
        nmi = 1'b0;
        intReq = 1'b0;
        waitReq = 1'b0;
        dataIn = 8'h00;
        {reqBus, reqNmi, reqInt, reqWait} = '0;
        row = rowTab[0];
        cycleNo = 0;
        raiseAt = -1;
        mPc = `CPU_PC_RESET;
        mSp = `CPU_SP_RESET;
        mR = 8'h00;
        repeat (2) @(posedge Clk);
        #2;
        rstN = 1'b1;
        @(negedge Clk);
        checkBus(1'b0, '0, strIdle);                  // reset step
        for (int i = 0; i < numRows; i++) begin
            row = rowTab[i];
            {reqBus, reqNmi, reqInt} = '0;
            cycleNo = 0;
            raiseAt = 1 + int'($urandom_range(1));     // step 1 or just after
            runSequence(kindFetch);
            if (row.busRq) runBusGrant();
            if (row.kind != kindFetch) runSequence(row.kind);
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+src
src/cpuCtlPkg.sv
src/stepCounter.sv
src/cycleDecoder.sv
src/regFile.sv
src/busInterface.sv
src/cpuCtlTop.sv
dv/cpuCtlTb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and judge the run by its log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    -f filelist.f --top-module cpuCtlTb -o cpuCtlSim \
    && ./obj_dir/cpuCtlSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation completed successfully" sim.log && echo "run passed" \
    || { echo "run failed"; exit 1; }
